// ==== logic/rs_pkg.sv ====
// Shared widths, sizes and the opcode encoding for the out-of-order back end.
// Every design file reaches these through rs_pkg:: scoped names.

package rs_pkg;

    localparam int DATA_WIDTH     = 32;    // one data word
    localparam int TAG_WIDTH      = 5;     // producer tag, a ROB index in a full core
    localparam int CDB_DEPTH      = 2;     // lane 0 is the ALU, lane 1 is the LSU
    localparam int RS_DEPTH       = 4;     // entries per reservation station
    localparam int MEM_ADDR_WIDTH = 4;     // word index into the LSU array
    localparam int OPCODE_WIDTH   = 3;

    // derived sizes
    localparam int RS_IDX_WIDTH   = $clog2(RS_DEPTH);
    localparam int MEM_DEPTH      = 2 ** MEM_ADDR_WIDTH;

    // slot index, which also serves as the age rank of an entry
    typedef logic [RS_IDX_WIDTH-1:0] rs_idx_t;

    // occupancy count, one bit wider so a full station fits
    typedef logic [RS_IDX_WIDTH:0] rs_cnt_t;

    // Arithmetic opcodes go to the ALU station, LOAD and STORE to the LSU station
    typedef enum logic [OPCODE_WIDTH-1:0] {
        ADD   = 3'd0,
        SUB   = 3'd1,
        AND   = 3'd2,
        XOR   = 3'd3,
        LOAD  = 3'd4,
        STORE = 3'd5
    } opcode_e;

endpackage

// ==== logic/rs_switch.sv ====
// Dispatch switch in front of the two reservation stations.
// Steers the enqueue to the ALU or LSU station by opcode, reports the stall of the
// targeted station and bypasses sources that are broadcast on the CDB this cycle.

module rs_switch (
    input  logic                              i_cdb_en      [0:rs_pkg::CDB_DEPTH-1],
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_cdb_data    [0:rs_pkg::CDB_DEPTH-1],
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_cdb_tag     [0:rs_pkg::CDB_DEPTH-1],

    input  logic                              i_rs_en,
    input  rs_pkg::opcode_e                   i_rs_opcode,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_src_tag  [0:1],
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_rs_src_data [0:1],
    input  logic                              i_rs_src_rdy  [0:1],
    input  logic                              i_rs_full     [0:1],

    output logic                              o_rs_en       [0:1],
    output logic [rs_pkg::DATA_WIDTH-1:0]     o_rs_src_data [0:1],
    output logic [rs_pkg::TAG_WIDTH-1:0]      o_rs_src_tag  [0:1],
    output logic                              o_rs_src_rdy  [0:1],
    output logic                              o_rs_stall
);

    logic is_lsu_op;

    assign is_lsu_op = (i_rs_opcode == rs_pkg::LOAD) || (i_rs_opcode == rs_pkg::STORE);

    // only the targeted station sees the enable
    assign o_rs_en[0] = i_rs_en & ~is_lsu_op;
    assign o_rs_en[1] = i_rs_en & is_lsu_op;

    // a full station only holds back the opcodes aimed at it
    assign o_rs_stall = is_lsu_op ? i_rs_full[1] : i_rs_full[0];

    // A producer that broadcasts in the dispatch cycle is gone by the time the
    // station could snoop it, so its result is folded in here instead
    always_comb begin
        for (int src = 0; src < 2; src++) begin
            o_rs_src_rdy[src]  = i_rs_src_rdy[src];
            o_rs_src_data[src] = i_rs_src_data[src];
            o_rs_src_tag[src]  = i_rs_src_tag[src];

            for (int lane = 0; lane < rs_pkg::CDB_DEPTH; lane++) begin
                if (!i_rs_src_rdy[src] && i_cdb_en[lane] &&
                    (i_cdb_tag[lane] == i_rs_src_tag[src])) begin
                    o_rs_src_rdy[src]  = 1'b1;                 // woken up on dispatch
                    o_rs_src_data[src] = i_cdb_data[lane];
                end
            end
        end
    end

endmodule

// ==== logic/rs_station.sv ====
// Reservation station with RS_DEPTH entries.
// Entries wait here until both sources are ready, capturing results from the CDB.
// Each cycle the oldest ready entry is issued to the unit, which never stalls.
// Age is kept as a rank per entry, 0 being the oldest valid entry.

module rs_station (
    input  logic                              clk,
    input  logic                              i_rst_n,

    input  logic                              i_cdb_en         [0:rs_pkg::CDB_DEPTH-1],
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_cdb_data       [0:rs_pkg::CDB_DEPTH-1],
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_cdb_tag        [0:rs_pkg::CDB_DEPTH-1],

    input  logic                              i_rs_en,
    input  rs_pkg::opcode_e                   i_rs_opcode,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_dst_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_rs_src_data    [0:1],
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_src_tag     [0:1],
    input  logic                              i_rs_src_rdy     [0:1],
    output logic                              o_rs_full,

    output logic                              o_issue_en,
    output rs_pkg::opcode_e                   o_issue_opcode,
    output logic [rs_pkg::TAG_WIDTH-1:0]      o_issue_dst_tag,
    output logic [rs_pkg::DATA_WIDTH-1:0]     o_issue_src_data [0:1]
);

    logic [rs_pkg::RS_DEPTH-1:0]          ent_valid;
    rs_pkg::rs_idx_t                      ent_age      [0:rs_pkg::RS_DEPTH-1];
    logic                                 ent_src_rdy  [0:rs_pkg::RS_DEPTH-1][0:1];
    rs_pkg::opcode_e                      ent_opcode   [0:rs_pkg::RS_DEPTH-1];
    logic [rs_pkg::TAG_WIDTH-1:0]         ent_dst_tag  [0:rs_pkg::RS_DEPTH-1];
    logic [rs_pkg::TAG_WIDTH-1:0]         ent_src_tag  [0:rs_pkg::RS_DEPTH-1][0:1];
    logic [rs_pkg::DATA_WIDTH-1:0]        ent_src_data [0:rs_pkg::RS_DEPTH-1][0:1];

    logic                                 snoop_hit    [0:rs_pkg::RS_DEPTH-1][0:1];
    logic [rs_pkg::DATA_WIDTH-1:0]        snoop_data   [0:rs_pkg::RS_DEPTH-1][0:1];

    logic                                 issue_found;
    rs_pkg::rs_idx_t                      issue_idx;
    rs_pkg::rs_idx_t                      issue_age;
    logic                                 free_found;
    rs_pkg::rs_idx_t                      free_idx;
    rs_pkg::rs_cnt_t                      valid_cnt;
    rs_pkg::rs_cnt_t                      enq_rank;
    logic                                 enq_en;

    assign o_rs_full = &ent_valid;
    assign enq_en    = i_rs_en & ~o_rs_full;           // a full station ignores dispatch

    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        issue_age   = '0;
        free_found  = 1'b0;
        free_idx    = '0;
        valid_cnt   = '0;

        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            // only ready bits from the start of the cycle count for issue
            if (ent_valid[i] && ent_src_rdy[i][0] && ent_src_rdy[i][1] &&
                (!issue_found || (ent_age[i] < issue_age))) begin
                issue_found = 1'b1;
                issue_idx   = rs_pkg::rs_idx_t'(i);
                issue_age   = ent_age[i];
            end
            if (!ent_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = rs_pkg::rs_idx_t'(i);
            end
            valid_cnt = valid_cnt + rs_pkg::rs_cnt_t'(ent_valid[i]);
        end

        // the new entry ranks behind everything that stays this cycle
        enq_rank = valid_cnt - rs_pkg::rs_cnt_t'(issue_found);

        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            for (int src = 0; src < 2; src++) begin
                snoop_hit[i][src]  = 1'b0;
                snoop_data[i][src] = ent_src_data[i][src];
                for (int lane = 0; lane < rs_pkg::CDB_DEPTH; lane++) begin
                    if (ent_valid[i] && !ent_src_rdy[i][src] && i_cdb_en[lane] &&
                        (i_cdb_tag[lane] == ent_src_tag[i][src])) begin
                        snoop_hit[i][src]  = 1'b1;
                        snoop_data[i][src] = i_cdb_data[lane];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ent_valid <= '0;
            for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
                ent_age[i]        <= '0;
                ent_src_rdy[i][0] <= 1'b0;
                ent_src_rdy[i][1] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
                for (int src = 0; src < 2; src++) begin
                    if (snoop_hit[i][src]) ent_src_rdy[i][src] <= 1'b1;
                end
                // entries younger than the issued one move up a rank
                if (issue_found && ent_valid[i] && (ent_age[i] > issue_age)) begin
                    ent_age[i] <= ent_age[i] - 1'b1;
                end
            end
            if (issue_found) ent_valid[issue_idx] <= 1'b0;
            if (enq_en) begin                          // the free slot is never the issued one
                ent_valid[free_idx]      <= 1'b1;
                ent_age[free_idx]        <= enq_rank[rs_pkg::RS_IDX_WIDTH-1:0];
                ent_src_rdy[free_idx][0] <= i_rs_src_rdy[0];
                ent_src_rdy[free_idx][1] <= i_rs_src_rdy[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            for (int src = 0; src < 2; src++) begin
                if (snoop_hit[i][src]) ent_src_data[i][src] <= snoop_data[i][src];
            end
        end
        if (enq_en) begin
            ent_opcode[free_idx]  <= i_rs_opcode;
            ent_dst_tag[free_idx] <= i_rs_dst_tag;
            for (int src = 0; src < 2; src++) begin
                ent_src_tag[free_idx][src]  <= i_rs_src_tag[src];
                ent_src_data[free_idx][src] <= i_rs_src_data[src];
            end
        end
    end

    assign o_issue_en          = issue_found;
    assign o_issue_opcode      = ent_opcode[issue_idx];
    assign o_issue_dst_tag     = ent_dst_tag[issue_idx];
    assign o_issue_src_data[0] = ent_src_data[issue_idx][0];
    assign o_issue_src_data[1] = ent_src_data[issue_idx][1];

endmodule

// ==== logic/alu_unit.sv ====
// Integer unit behind the ALU station.
// Takes one issued instruction per cycle and broadcasts its result on CDB lane 0
// in the following cycle.

module alu_unit (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_issue_en,
    input  rs_pkg::opcode_e                   i_issue_opcode,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_issue_dst_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_issue_src_data [0:1],
    output logic                              o_cdb_en,
    output logic [rs_pkg::TAG_WIDTH-1:0]      o_cdb_tag,
    output logic [rs_pkg::DATA_WIDTH-1:0]     o_cdb_data
);

    logic [rs_pkg::DATA_WIDTH-1:0] alu_result;

    always_comb begin
        case (i_issue_opcode)
            rs_pkg::ADD: alu_result = i_issue_src_data[0] + i_issue_src_data[1];
            rs_pkg::SUB: alu_result = i_issue_src_data[0] - i_issue_src_data[1];
            rs_pkg::AND: alu_result = i_issue_src_data[0] & i_issue_src_data[1];
            rs_pkg::XOR: alu_result = i_issue_src_data[0] ^ i_issue_src_data[1];
            default:     alu_result = '0;              // memory ops never reach this unit
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) o_cdb_en <= 1'b0;
        else          o_cdb_en <= i_issue_en;          // lane valid for one cycle per issue
    end

    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_cdb_tag  <= i_issue_dst_tag;
            o_cdb_data <= alu_result;
        end
    end

endmodule

// ==== logic/lsu_unit.sv ====
// Load/store unit behind the LSU station, backed by a small word array.
// Source 0 gives the word address and source 1 the store data. Both LOAD and
// STORE broadcast on CDB lane 1 one cycle after issue.

module lsu_unit (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_issue_en,
    input  rs_pkg::opcode_e                   i_issue_opcode,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_issue_dst_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_issue_src_data [0:1],
    output logic                              o_cdb_en,
    output logic [rs_pkg::TAG_WIDTH-1:0]      o_cdb_tag,
    output logic [rs_pkg::DATA_WIDTH-1:0]     o_cdb_data
);

    logic [rs_pkg::DATA_WIDTH-1:0]     mem [0:rs_pkg::MEM_DEPTH-1];
    logic [rs_pkg::MEM_ADDR_WIDTH-1:0] mem_addr;
    logic                              is_store;
    logic [rs_pkg::DATA_WIDTH-1:0]     lsu_result;

    assign mem_addr = i_issue_src_data[0][rs_pkg::MEM_ADDR_WIDTH-1:0];  // upper bits ignored
    assign is_store = (i_issue_opcode == rs_pkg::STORE);

    // a store echoes the value it writes
    assign lsu_result = is_store ? i_issue_src_data[1] : mem[mem_addr];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cdb_en <= 1'b0;
            for (int i = 0; i < rs_pkg::MEM_DEPTH; i++) begin
                mem[i] <= '0;                          // unwritten words load as zero
            end
        end else begin
            o_cdb_en <= i_issue_en;
            if (i_issue_en && is_store) mem[mem_addr] <= i_issue_src_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_cdb_tag  <= i_issue_dst_tag;
            o_cdb_data <= lsu_result;
        end
    end

endmodule

// ==== logic/rs_core.sv ====
// Top level of the back end.
// A dispatch switch feeds the ALU and LSU reservation stations, each station issues
// to its own unit, and the two units drive the two CDB lanes.

module rs_core (
    input  logic                              clk,
    input  logic                              i_rst_n,

    input  logic                              i_rs_en,
    input  rs_pkg::opcode_e                   i_rs_opcode,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_dst_tag,
    input  logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_src_tag  [0:1],
    input  logic [rs_pkg::DATA_WIDTH-1:0]     i_rs_src_data [0:1],
    input  logic                              i_rs_src_rdy  [0:1],
    output logic                              o_rs_stall,

    output logic                              o_cdb_en      [0:rs_pkg::CDB_DEPTH-1],
    output logic [rs_pkg::TAG_WIDTH-1:0]      o_cdb_tag     [0:rs_pkg::CDB_DEPTH-1],
    output logic [rs_pkg::DATA_WIDTH-1:0]     o_cdb_data    [0:rs_pkg::CDB_DEPTH-1]
);

    // switch to stations, index 0 is ALU and 1 is LSU
    logic                              sw_rs_en       [0:1];
    logic [rs_pkg::DATA_WIDTH-1:0]     sw_src_data    [0:1];
    logic [rs_pkg::TAG_WIDTH-1:0]      sw_src_tag     [0:1];
    logic                              sw_src_rdy     [0:1];
    logic                              rs_full        [0:1];

    // station to unit
    logic                              alu_issue_en;
    rs_pkg::opcode_e                   alu_issue_opcode;
    logic [rs_pkg::TAG_WIDTH-1:0]      alu_issue_dst_tag;
    logic [rs_pkg::DATA_WIDTH-1:0]     alu_issue_src_data [0:1];
    logic                              lsu_issue_en;
    rs_pkg::opcode_e                   lsu_issue_opcode;
    logic [rs_pkg::TAG_WIDTH-1:0]      lsu_issue_dst_tag;
    logic [rs_pkg::DATA_WIDTH-1:0]     lsu_issue_src_data [0:1];

    rs_switch rs_switch_i (
        .i_cdb_en(o_cdb_en), .i_cdb_data(o_cdb_data), .i_cdb_tag(o_cdb_tag),
        .i_rs_en(i_rs_en), .i_rs_opcode(i_rs_opcode),
        .i_rs_src_tag(i_rs_src_tag), .i_rs_src_data(i_rs_src_data),
        .i_rs_src_rdy(i_rs_src_rdy), .i_rs_full(rs_full),
        .o_rs_en(sw_rs_en), .o_rs_src_data(sw_src_data), .o_rs_src_tag(sw_src_tag),
        .o_rs_src_rdy(sw_src_rdy), .o_rs_stall(o_rs_stall)
    );

    rs_station alu_rs_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_cdb_en(o_cdb_en), .i_cdb_data(o_cdb_data), .i_cdb_tag(o_cdb_tag),
        .i_rs_en(sw_rs_en[0]), .i_rs_opcode(i_rs_opcode), .i_rs_dst_tag(i_rs_dst_tag),
        .i_rs_src_data(sw_src_data), .i_rs_src_tag(sw_src_tag), .i_rs_src_rdy(sw_src_rdy),
        .o_rs_full(rs_full[0]),
        .o_issue_en(alu_issue_en), .o_issue_opcode(alu_issue_opcode),
        .o_issue_dst_tag(alu_issue_dst_tag), .o_issue_src_data(alu_issue_src_data)
    );

    rs_station lsu_rs_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_cdb_en(o_cdb_en), .i_cdb_data(o_cdb_data), .i_cdb_tag(o_cdb_tag),
        .i_rs_en(sw_rs_en[1]), .i_rs_opcode(i_rs_opcode), .i_rs_dst_tag(i_rs_dst_tag),
        .i_rs_src_data(sw_src_data), .i_rs_src_tag(sw_src_tag), .i_rs_src_rdy(sw_src_rdy),
        .o_rs_full(rs_full[1]),
        .o_issue_en(lsu_issue_en), .o_issue_opcode(lsu_issue_opcode),
        .o_issue_dst_tag(lsu_issue_dst_tag), .o_issue_src_data(lsu_issue_src_data)
    );

    // each unit owns one lane, so the CDB needs no arbiter
    alu_unit alu_unit_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_issue_en(alu_issue_en), .i_issue_opcode(alu_issue_opcode),
        .i_issue_dst_tag(alu_issue_dst_tag), .i_issue_src_data(alu_issue_src_data),
        .o_cdb_en(o_cdb_en[0]), .o_cdb_tag(o_cdb_tag[0]), .o_cdb_data(o_cdb_data[0])
    );

    lsu_unit lsu_unit_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_issue_en(lsu_issue_en), .i_issue_opcode(lsu_issue_opcode),
        .i_issue_dst_tag(lsu_issue_dst_tag), .i_issue_src_data(lsu_issue_src_data),
        .o_cdb_en(o_cdb_en[1]), .o_cdb_tag(o_cdb_tag[1]), .o_cdb_data(o_cdb_data[1])
    );

endmodule

// ==== tests/rs_core_chk.sv ====
// Concurrent assertions for the out-of-order back end, bound into rs_core.
// Covers reset behavior, no acceptance under stall, CDB lane ownership and one
// broadcast per dispatched tag.

module rs_core_chk (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_rs_en,
    input  logic [rs_pkg::TAG_WIDTH-1:0]  i_rs_dst_tag,
    input  logic                          o_rs_stall,
    input  logic                          sw_rs_en     [0:1],
    input  logic                          rs_full      [0:1],
    input  logic                          alu_issue_en,
    input  rs_pkg::opcode_e               alu_issue_opcode,
    input  logic                          lsu_issue_en,
    input  logic                          o_cdb_en     [0:rs_pkg::CDB_DEPTH-1],
    input  logic [rs_pkg::TAG_WIDTH-1:0]  o_cdb_tag    [0:rs_pkg::CDB_DEPTH-1]
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [2**rs_pkg::TAG_WIDTH-1:0] in_flight;    // one bit per accepted, unbroadcast tag

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_flight <= '0;
        end else begin
            for (int lane = 0; lane < rs_pkg::CDB_DEPTH; lane++) begin
                if (o_cdb_en[lane]) in_flight[o_cdb_tag[lane]] <= 1'b0;
            end
            if (i_rs_en && !o_rs_stall) in_flight[i_rs_dst_tag] <= 1'b1;
        end
    end

    reset_quiet_a: assert property (@(posedge clk)
        !i_rst_n |-> !o_cdb_en[0] && !o_cdb_en[1] && !o_rs_stall)
        else $error("CDB or stall active during reset");

    after_reset_a: assert property (@(posedge clk)
        $rose(i_rst_n) |-> !o_cdb_en[0] && !o_cdb_en[1] && !o_rs_stall)
        else $error("CDB or stall active in the first cycle after reset");

    // a stalled dispatch must not reach a station that can take it
    no_accept_stall_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_rs_en && o_rs_stall) |-> !(sw_rs_en[0] && !rs_full[0]) &&
                                    !(sw_rs_en[1] && !rs_full[1]))
        else $error("instruction accepted while stall was high");

    alu_no_mem_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        alu_issue_en |-> !(alu_issue_opcode inside {rs_pkg::LOAD, rs_pkg::STORE}))
        else $error("load or store issued to the ALU");

    lane0_owner_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cdb_en[0] |-> $past(alu_issue_en))
        else $error("lane 0 driven without an ALU issue");

    lane1_owner_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cdb_en[1] |-> $past(lsu_issue_en))
        else $error("lane 1 driven without an LSU issue");

    // a second broadcast of the same dispatch finds its tag already retired
    lane0_once_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cdb_en[0] |-> in_flight[o_cdb_tag[0]])
        else $error("tag broadcast on lane 0 without an outstanding dispatch");

    lane1_once_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cdb_en[1] |-> in_flight[o_cdb_tag[1]])
        else $error("tag broadcast on lane 1 without an outstanding dispatch");

endmodule

bind rs_core rs_core_chk chk_i (
    .clk(clk), .i_rst_n(i_rst_n), .i_rs_en(i_rs_en), .i_rs_dst_tag(i_rs_dst_tag),
    .o_rs_stall(o_rs_stall), .sw_rs_en(sw_rs_en), .rs_full(rs_full),
    .alu_issue_en(alu_issue_en), .alu_issue_opcode(alu_issue_opcode),
    .lsu_issue_en(lsu_issue_en), .o_cdb_en(o_cdb_en), .o_cdb_tag(o_cdb_tag)
);

// ==== tests/rs_core_tb.sv ====
// Testbench for rs_core acting as the dispatcher.
// Drives ALU, dependency, bypass, load/store and back-pressure sequences and
// checks every CDB broadcast against its own model of the opcodes and memory.

module rs_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 60;
    localparam logic [31:0] SEED = 32'h2b66_85b8;

    logic                              clk;
    logic                              i_rst_n;
    logic                              i_rs_en;
    rs_pkg::opcode_e                   i_rs_opcode;
    logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_dst_tag;
    logic [rs_pkg::TAG_WIDTH-1:0]      i_rs_src_tag  [0:1];
    logic [rs_pkg::DATA_WIDTH-1:0]     i_rs_src_data [0:1];
    logic                              i_rs_src_rdy  [0:1];
    logic                              o_rs_stall;
    logic                              o_cdb_en      [0:rs_pkg::CDB_DEPTH-1];
    logic [rs_pkg::TAG_WIDTH-1:0]      o_cdb_tag     [0:rs_pkg::CDB_DEPTH-1];
    logic [rs_pkg::DATA_WIDTH-1:0]     o_cdb_data    [0:rs_pkg::CDB_DEPTH-1];

    logic [31:0] rng_state;
    logic [31:0] exp_val   [0:31];            // expected broadcast value per tag
    logic        pending   [0:31];
    logic        done      [0:31];
    logic        is_mem    [0:31];
    logic [31:0] mem_model [0:15];
    logic [4:0]  mon_tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] p;
    string       test_name;

    rs_core dut_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_rs_en(i_rs_en), .i_rs_opcode(i_rs_opcode),
        .i_rs_dst_tag(i_rs_dst_tag), .i_rs_src_tag(i_rs_src_tag),
        .i_rs_src_data(i_rs_src_data), .i_rs_src_rdy(i_rs_src_rdy),
        .o_rs_stall(o_rs_stall), .o_cdb_en(o_cdb_en), .o_cdb_tag(o_cdb_tag),
        .o_cdb_data(o_cdb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] alu_model(rs_pkg::opcode_e op, logic [31:0] x,
                                              logic [31:0] y);
        case (op)
            rs_pkg::ADD: return x + y;
            rs_pkg::SUB: return x - y;
            rs_pkg::AND: return x & y;
            default:     return x ^ y;
        endcase
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // entered and left on a falling edge; holds the instruction while stalled
    task automatic dispatch(rs_pkg::opcode_e op, logic [4:0] dst, logic r0, logic [4:0] t0,
                            logic [31:0] d0, logic r1, logic [4:0] t1, logic [31:0] d1,
                            logic [31:0] expv);
        int n;
        n = 0;
        exp_val[dst] = expv;
        is_mem[dst]  = (op == rs_pkg::LOAD) || (op == rs_pkg::STORE);
        done[dst]    = 1'b0;
        pending[dst] = 1'b1;
        i_rs_en = 1'b1;
        i_rs_opcode = op;
        i_rs_dst_tag = dst;
        i_rs_src_rdy[0] = r0;
        i_rs_src_tag[0] = t0;
        i_rs_src_data[0] = d0;
        i_rs_src_rdy[1] = r1;
        i_rs_src_tag[1] = t1;
        i_rs_src_data[1] = d1;
        #5;
        while (o_rs_stall) begin
            if (n >= TIMEOUT_CYCLES) begin
                fail_now($sformatf("dispatch of tag %0d was never accepted", dst));
            end else begin
                @(negedge clk);
                #5;
                n++;
            end
        end
        @(posedge clk);
        @(negedge clk);
        i_rs_en = 1'b0;
    endtask

    task automatic wait_tag(logic [4:0] tag);
        int n;
        n = 0;
        while (!done[tag]) begin
            if (n >= TIMEOUT_CYCLES) begin
                fail_now($sformatf("tag %0d never appeared on the CDB", tag));
            end else begin
                @(posedge clk);
                n++;
            end
        end
        @(negedge clk);
    endtask

    // the request is raised only where the stall has to hold it back
    task automatic expect_stall(rs_pkg::opcode_e op, logic level);
        i_rs_en = level;
        i_rs_opcode = op;
        #5;
        if (o_rs_stall !== level) begin
            fail_now($sformatf("CHECK FAILED: %s stall for %s expected %0b actual %0b",
                               test_name, op.name(), level, o_rs_stall));
        end
        @(negedge clk);
        i_rs_en = 1'b0;
    endtask

    // scoreboard on both lanes, sampled away from the rising edge
    always @(negedge clk) begin
        if (i_rst_n) begin
            for (int lane = 0; lane < rs_pkg::CDB_DEPTH; lane++) begin
                if (o_cdb_en[lane]) begin
                    mon_tag = o_cdb_tag[lane];
                    if (!pending[mon_tag]) begin
                        fail_now($sformatf("tag %0d broadcast without a pending dispatch",
                                           mon_tag));
                    end else if (is_mem[mon_tag] != (lane == 1)) begin
                        fail_now($sformatf("tag %0d broadcast on the wrong lane %0d",
                                           mon_tag, lane));
                    end else if (o_cdb_data[lane] !== exp_val[mon_tag]) begin
                        fail_now($sformatf("CHECK FAILED: %s tag %0d expected %h actual %h",
                                           test_name, mon_tag, exp_val[mon_tag],
                                           o_cdb_data[lane]));
                    end else begin
                        pending[mon_tag] = 1'b0;
                        done[mon_tag]    = 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        rng_state = SEED;
        i_rst_n = 1'b0;
        i_rs_en = 1'b0;
        i_rs_opcode = rs_pkg::ADD;
        i_rs_dst_tag = '0;
        for (int s = 0; s < 2; s++) begin
            i_rs_src_tag[s] = '0;
            i_rs_src_data[s] = '0;
            i_rs_src_rdy[s] = 1'b0;
        end
        for (int t = 0; t < 32; t++) begin
            pending[t] = 1'b0;
            done[t] = 1'b0;
            is_mem[t] = 1'b0;
            exp_val[t] = '0;
        end
        for (int m = 0; m < 16; m++) mem_model[m] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);

        test_name = "alu_ops";
        for (int k = 0; k < 4; k++) begin
            a = next_rand();
            b = next_rand();
            dispatch(rs_pkg::opcode_e'(k), 5'(k), 1, 0, a, 1, 0, b,
                     alu_model(rs_pkg::opcode_e'(k), a, b));
        end
        for (int k = 0; k < 4; k++) wait_tag(5'(k));

        test_name = "wakeup";
        a = next_rand();
        b = next_rand();
        p = a + b;
        dispatch(rs_pkg::ADD, 10, 1, 0, a, 1, 0, b, p);
        b = next_rand();
        dispatch(rs_pkg::SUB, 11, 0, 10, 0, 1, 0, b, p - b);
        a = next_rand();
        b = next_rand();
        p = a & b;
        dispatch(rs_pkg::XOR, 12, 1, 0, a, 0, 13, 0, a ^ p);   // producer comes later
        dispatch(rs_pkg::AND, 13, 1, 0, a, 1, 0, b, p);
        wait_tag(11);
        wait_tag(12);

        test_name = "bypass";
        a = next_rand();
        b = next_rand();
        p = a + b;
        dispatch(rs_pkg::ADD, 14, 1, 0, a, 1, 0, b, p);
        @(negedge clk);                        // consumer lands while tag 14 is on the CDB
        dispatch(rs_pkg::ADD, 15, 0, 14, 0, 0, 14, 0, p + p);
        wait_tag(15);

        test_name = "load_store";
        for (int k = 0; k < 6; k++) begin
            a = next_rand();
            b = next_rand();
            if (k % 2 == 0) begin
                mem_model[a[3:0]] = b;
                dispatch(rs_pkg::STORE, 5'(16 + k), 1, 0, a, 1, 0, b, b);
            end else begin
                dispatch(rs_pkg::LOAD, 5'(16 + k), 1, 0, a, 1, 0, b, mem_model[a[3:0]]);
            end
            wait_tag(5'(16 + k));
            b = next_rand();
            dispatch(rs_pkg::LOAD, 5'(16 + k), 1, 0, a, 1, 0, b, mem_model[a[3:0]]);
            wait_tag(5'(16 + k));
        end

        test_name = "backpressure";
        a = next_rand();
        b = next_rand();
        p = a - b;
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) begin
            dispatch(rs_pkg::ADD, 5'(24 + k), 0, 30, 0, 1, 0, 32'(k), p + 32'(k));
        end
        expect_stall(rs_pkg::ADD, 1'b1);
        expect_stall(rs_pkg::LOAD, 1'b0);
        a = next_rand();
        dispatch(rs_pkg::LOAD, 29, 1, 0, a, 1, 0, 0, mem_model[a[3:0]]);
        wait_tag(29);
        a = next_rand();
        mem_model[a[3:0]] = p;
        // the ALU station is full, so the producer enters through the LSU station
        dispatch(rs_pkg::STORE, 30, 1, 0, a, 1, 0, p, p);
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) wait_tag(5'(24 + k));
        wait_tag(30);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/rs_pkg.sv
logic/rs_switch.sv
logic/rs_station.sv
logic/alu_unit.sv
logic/lsu_unit.sv
logic/rs_core.sv
tests/rs_core_chk.sv
tests/rs_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the rs_core testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rs_core_tb -f filelist.f -o rs_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rs_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
